// ==== rv_serial_top.f ====
logic/rv_serial_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/regfile.sv
logic/serial_exec_stage.sv
logic/store_stage.sv
logic/rv_serial_top.sv
dv/tb_clock_gen.sv
dv/tb_rv_serial_top.sv

// ==== dv/rv_serial_testdata.txt ====
# I <address> <instruction word>, F <expected fetch address>, S <store address> <store data>
# All values hex. F and S records are checked in file order
I 00000100 123450B7
I 00000104 67808093
I 00000108 FFF00113
I 0000010C 00001537
I 00000110 00152023
I 00000114 00252223
I 00000118 0F00F193
I 0000011C F000E213
I 00000120 7FF0C293
I 00000124 00352423
I 00000128 00452623
I 0000012C 00552823
I 00000130 00208333
I 00000134 401003B3
I 00000138 0050F433
I 0000013C 0071E4B3
I 00000140 0020C5B3
I 00000144 10050613
I 00000148 FE662E23
I 0000014C FE762C23
I 00000150 FE862A23
I 00000154 80962023
I 00000158 00B52A23
I 0000015C 00508013
I 00000160 00409093
I 00000164 00002083
I 00000168 00052C23
I 0000016C 00152E23
# Fetch order, one step of 4 per retired instruction
F 00000100
F 00000104
F 00000108
F 0000010C
F 00000110
F 00000114
F 00000118
F 0000011C
F 00000120
F 00000124
F 00000128
F 0000012C
F 00000130
F 00000134
F 00000138
F 0000013C
F 00000140
F 00000144
F 00000148
F 0000014C
F 00000150
F 00000154
F 00000158
F 0000015C
F 00000160
F 00000164
F 00000168
F 0000016C
F 00000170
# lui/addi, then andi/ori/xori results
S 00001000 12345678
S 00001004 FFFFFFFF
S 00001008 00000070
S 0000100C FFFFFF78
S 00001010 12345187
# add, sub, and, or through negative offsets
S 000010FC 12345677
S 000010F8 EDCBA988
S 000010F4 12345000
S 00000900 EDCBA9F8
S 00001014 EDCBA987
# x0 stays zero, x1 untouched by the no-ops
S 00001018 00000000
S 0000101C 12345678

// ==== dv/tb_rv_serial_top.sv ====
`timescale 1ns/1ps

module tb_rv_serial_top import rv_serial_pkg::*; ();

   localparam word_t RESET_PC     = 32'h100;
   localparam int    IBUS_TIMEOUT = 200;
   localparam int    DBUS_TIMEOUT = 2000;
   localparam int    END_TIMEOUT  = 5000;
   localparam int    DELAY_N      = 64;

   logic       clk;
   logic       rst_n;
   logic       ibus_cyc;
   word_t      ibus_adr;
   word_t      ibus_rdt;
   logic       ibus_ack;
   logic       dbus_cyc;
   word_t      dbus_adr;
   word_t      dbus_dat;
   logic       dbus_ack;

   word_t      imem [256];
   word_t      exp_fetch [$];
   store_req_t exp_store [$];
   int         ibus_delay [DELAY_N];
   int         dbus_delay [DELAY_N];
   int         stores_seen;
   int         stores_total;

   tb_clock_gen #(
      .PERIOD_NS    (20.0),
      .RESET_CYCLES (2)
   ) u_tb_clock_gen (
      .clk     (clk),
      .o_rst_n (rst_n)
   );

   rv_serial_top #(
      .RESET_PC (RESET_PC)
   ) u_rv_serial_top (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_cyc (ibus_cyc),
      .o_ibus_adr (ibus_adr),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_cyc (dbus_cyc),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .i_dbus_ack (dbus_ack)
   );

   // Unused words decode as a custom opcode, so they retire as no-ops
   function automatic word_t fill_word(input word_t adr);
      return {adr[31:7] ^ {18'b0, adr[6:0]}, 7'b0001011};
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("[FAIL] %0t ns: %s is %08h, expected %08h", $time, what, got, exp));
      end
   endtask

   task automatic load_testdata();
      int         fd;
      int         code;
      int         ch;
      logic [7:0] tag;
      word_t      a;
      word_t      d;
      store_req_t req;
      fd = $fopen("dv/rv_serial_testdata.txt", "r");
      if (fd == 0) begin
         abort_run("Cannot open the test data file dv/rv_serial_testdata.txt");
      end
      code = $fscanf(fd, " %c", tag);
      while (code == 1) begin
         case (tag)
            "#": begin
               ch = $fgetc(fd);
               while (ch != 10 && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end
            "I": begin
               if ($fscanf(fd, "%h %h", a, d) != 2) abort_run("Bad instruction record in test data");
               imem[a[9:2]] = d;
            end
            "F": begin
               if ($fscanf(fd, "%h", a) != 1) abort_run("Bad fetch record in test data");
               exp_fetch.push_back(a);
            end
            "S": begin
               if ($fscanf(fd, "%h %h", a, d) != 2) abort_run("Bad store record in test data");
               req.adr = a;
               req.dat = d;
               exp_store.push_back(req);
            end
            default: abort_run($sformatf("Unknown record type %c in test data", tag));
         endcase
         code = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
   endtask

   initial begin
      int waited;
      ibus_rdt    = '0;
      ibus_ack    = 1'b0;
      dbus_ack    = 1'b0;
      stores_seen = 0;
      void'($urandom(71739));
      // Wait cycles per bus cycle, 0 to 3
      for (int i = 0; i < DELAY_N; i++) begin
         ibus_delay[i] = $urandom % 4;
         dbus_delay[i] = $urandom % 4;
      end
      for (int i = 0; i < 256; i++) begin
         imem[i] = fill_word(word_t'(i) << 2);
      end
      load_testdata();
      stores_total = exp_store.size();
      waited = 0;
      @(posedge clk);
      while (stores_seen < stores_total || exp_fetch.size() != 0) begin
         if (waited == END_TIMEOUT) begin
            abort_run("Run did not finish: expected stores or fetches never appeared");
         end
         waited = waited + 1;
         @(posedge clk);
      end
      $display("All tests passed");
      $finish;
   end

   // Instruction memory with 0 to 3 wait cycles per fetch
   initial begin : ibus_responder
      int    waited;
      int    delay;
      int    n;
      word_t adr;
      n = 0;
      forever begin
         waited = 0;
         @(posedge clk);
         while (ibus_cyc !== 1'b1) begin
            if (waited == IBUS_TIMEOUT) begin
               abort_run("Instruction bus stalled: no fetch request within the timeout");
            end
            waited = waited + 1;
            @(posedge clk);
         end
         adr = ibus_adr;
         if (exp_fetch.size() == 0) abort_run("Fetch past the end of the expected program");
         check_value("fetch address", adr, exp_fetch.pop_front());
         delay = ibus_delay[n % DELAY_N];
         n = n + 1;
         repeat (delay) @(posedge clk);
         check_value("held fetch address", ibus_adr, adr);
         ibus_rdt <= imem[adr[9:2]];
         ibus_ack <= 1'b1;
         @(posedge clk);
         ibus_ack <= 1'b0;
      end
   end

   // Data bus takes word stores only
   initial begin : dbus_responder
      int         waited;
      int         delay;
      int         n;
      store_req_t front;
      n = 0;
      forever begin
         waited = 0;
         @(posedge clk);
         while (dbus_cyc !== 1'b1) begin
            if (waited == DBUS_TIMEOUT) begin
               abort_run("Data bus stalled: no store request within the timeout");
            end
            waited = waited + 1;
            @(posedge clk);
         end
         if (exp_store.size() == 0) abort_run("Store seen after all expected stores");
         front = exp_store.pop_front();
         check_value("store address", dbus_adr, front.adr);
         check_value("store data", dbus_dat, front.dat);
         delay = dbus_delay[n % DELAY_N];
         n = n + 1;
         repeat (delay) @(posedge clk);
         check_value("held store address", dbus_adr, front.adr);
         check_value("held store data", dbus_dat, front.dat);
         dbus_ack    <= 1'b1;
         stores_seen = stores_seen + 1;
         @(posedge clk);
         dbus_ack <= 1'b0;
      end
   end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS    = 20.0,
   parameter int  RESET_CYCLES = 2
) (
   output logic clk,
   output logic o_rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   // Reset released on a rising edge
   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      o_rst_n <= 1'b1;
   end

endmodule

// ==== logic/rv_serial_top.sv ====
`timescale 1ns/1ps

module rv_serial_top import rv_serial_pkg::*; #(
   parameter word_t RESET_PC = 32'h0
) (
   input  logic  clk,
   input  logic  i_rst_n,
   output logic  o_ibus_cyc,
   output word_t o_ibus_adr,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,
   output logic  o_dbus_cyc,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat,
   input  logic  i_dbus_ack
);

   instr_t     instr;
   logic       instr_valid;
   exec_ctrl_t ctrl;
   logic       start;
   reg_addr_t  rs1_addr;
   reg_addr_t  rs2_addr;
   word_t      rs1_data;
   word_t      rs2_data;
   wb_t        wb;
   store_req_t store;
   logic       store_start;
   logic       exec_retire;
   logic       store_retire;
   logic       retire;

   // Only one of the two can retire a given instruction
   assign retire = exec_retire | store_retire;

   fetch_stage #(
      .RESET_PC (RESET_PC)
   ) u_fetch_stage (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_retire      (retire),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_ibus_adr    (o_ibus_adr),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .o_instr       (instr),
      .o_instr_valid (instr_valid)
   );

   decode_stage u_decode_stage (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr       (instr),
      .i_instr_valid (instr_valid),
      .o_ctrl        (ctrl),
      .o_start       (start)
   );

   regfile u_regfile (
      .clk        (clk),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_wb       (wb)
   );

   serial_exec_stage u_serial_exec_stage (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ctrl        (ctrl),
      .i_start       (start),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .i_rs1_data    (rs1_data),
      .i_rs2_data    (rs2_data),
      .o_wb          (wb),
      .o_store       (store),
      .o_store_start (store_start),
      .o_retire      (exec_retire)
   );

   store_stage u_store_stage (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_store       (store),
      .i_store_start (store_start),
      .o_dbus_cyc    (o_dbus_cyc),
      .o_dbus_adr    (o_dbus_adr),
      .o_dbus_dat    (o_dbus_dat),
      .i_dbus_ack    (i_dbus_ack),
      .o_retire      (store_retire)
   );

endmodule

// ==== logic/store_stage.sv ====
`timescale 1ns/1ps

module store_stage import rv_serial_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   input  store_req_t i_store,
   input  logic       i_store_start,
   output logic       o_dbus_cyc,
   output word_t      o_dbus_adr,
   output word_t      o_dbus_dat,
   input  logic       i_dbus_ack,
   output logic       o_retire
);

   store_req_t req;

   assign o_dbus_adr = req.adr;
   assign o_dbus_dat = req.dat;

   // Store ends on the ack cycle
   assign o_retire = o_dbus_cyc & i_dbus_ack;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_dbus_cyc <= 1'b0;
      end else if (i_store_start) begin
         o_dbus_cyc <= 1'b1;
      end else if (i_dbus_ack) begin
         o_dbus_cyc <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (i_store_start) begin
         req <= i_store;
      end
   end

endmodule

// ==== logic/serial_exec_stage.sv ====
`timescale 1ns/1ps

module serial_exec_stage import rv_serial_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   input  exec_ctrl_t i_ctrl,
   input  logic       i_start,
   output reg_addr_t  o_rs1_addr,
   output reg_addr_t  o_rs2_addr,
   input  word_t      i_rs1_data,
   input  word_t      i_rs2_data,
   output wb_t        o_wb,
   output store_req_t o_store,
   output logic       o_store_start,
   output logic       o_retire
);

   logic             busy;
   logic             done;
   logic [CNT_W-1:0] cnt;
   word_t            op_a;
   word_t            op_b;
   word_t            res;
   word_t            st_data;
   logic             carry;
   logic             is_sub;
   logic             b_bit;
   logic             sum_bit;
   logic             carry_nxt;
   logic             res_bit;

   assign o_rs1_addr = i_ctrl.rs1;
   assign o_rs2_addr = i_ctrl.rs2;

   // One-bit adder, B inverted for subtraction
   always_comb begin
      is_sub    = (i_ctrl.alu_op == ALU_SUB);
      b_bit     = op_b[0] ^ is_sub;
      sum_bit   = op_a[0] ^ b_bit ^ carry;
      carry_nxt = (op_a[0] & b_bit) | (op_a[0] & carry) | (b_bit & carry);
      case (i_ctrl.alu_op)
         ALU_AND:    res_bit = op_a[0] & op_b[0];
         ALU_OR:     res_bit = op_a[0] | op_b[0];
         ALU_XOR:    res_bit = op_a[0] ^ op_b[0];
         ALU_PASS_B: res_bit = op_b[0];
         default:    res_bit = sum_bit;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy <= 1'b0;
         done <= 1'b0;
         cnt  <= '0;
      end else begin
         done <= 1'b0;
         if (i_start) begin
            busy <= 1'b1;
            cnt  <= '0;
         end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == '1) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_start) begin
         op_a    <= i_ctrl.zero_a ? '0 : i_rs1_data;
         op_b    <= i_ctrl.use_imm ? i_ctrl.imm : i_rs2_data;
         st_data <= i_rs2_data;
         carry   <= is_sub;
      end else if (busy) begin
         op_a  <= {1'b0, op_a[XLEN-1:1]};
         op_b  <= {1'b0, op_b[XLEN-1:1]};
         res   <= {res_bit, res[XLEN-1:1]};
         carry <= carry_nxt;
      end
   end

   always_comb begin
      o_wb.en       = done & i_ctrl.writes_rd;
      o_wb.rd       = i_ctrl.rd;
      o_wb.data     = res;
      o_store.adr   = res;
      o_store.dat   = st_data;
      o_store_start = done & i_ctrl.is_store;
      o_retire      = done & !i_ctrl.is_store;
   end

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile import rv_serial_pkg::*; (
   input  logic      clk,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   output word_t     o_rs1_data,
   output word_t     o_rs2_data,
   input  wb_t       i_wb
);

   word_t regs [2**REG_AW];

   always_ff @(posedge clk) begin
      if (i_wb.en) begin
         regs[i_wb.rd] <= i_wb.data;
      end
   end

   // x0 reads back as zero
   always_comb begin
      o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
      o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];
   end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import rv_serial_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   input  instr_t     i_instr,
   input  logic       i_instr_valid,
   output exec_ctrl_t o_ctrl,
   output logic       o_start
);

   exec_ctrl_t ctrl_d;
   logic       kept;

   always_comb begin
      kept           = 1'b0;
      ctrl_d         = '0;
      ctrl_d.alu_op  = ALU_ADD;
      ctrl_d.rd      = i_instr.r.rd;
      ctrl_d.rs1     = i_instr.r.rs1;
      ctrl_d.rs2     = i_instr.r.rs2;

      case (i_instr.r.opcode)
         OPC_OP: begin
            kept = (i_instr.r.funct7 == 7'b0000000);
            case (i_instr.r.funct3)
               3'b000: begin
                  ctrl_d.alu_op = i_instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                  kept = kept || (i_instr.r.funct7 == 7'b0100000);
               end
               3'b100: ctrl_d.alu_op = ALU_XOR;
               3'b110: ctrl_d.alu_op = ALU_OR;
               3'b111: ctrl_d.alu_op = ALU_AND;
               default: kept = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            kept           = 1'b1;
            ctrl_d.use_imm = 1'b1;
            ctrl_d.imm     = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
            case (i_instr.i.funct3)
               3'b000: ctrl_d.alu_op = ALU_ADD;
               3'b100: ctrl_d.alu_op = ALU_XOR;
               3'b110: ctrl_d.alu_op = ALU_OR;
               3'b111: ctrl_d.alu_op = ALU_AND;
               // SLTI and shifts are not executed
               default: kept = 1'b0;
            endcase
         end
         OPC_LUI: begin
            kept           = 1'b1;
            ctrl_d.alu_op  = ALU_PASS_B;
            ctrl_d.use_imm = 1'b1;
            ctrl_d.zero_a  = 1'b1;
            ctrl_d.imm     = {i_instr.u.imm, 12'b0};
         end
         OPC_STORE: begin
            // Word stores only
            kept            = (i_instr.s.funct3 == 3'b010);
            ctrl_d.use_imm  = 1'b1;
            ctrl_d.is_store = kept;
            ctrl_d.imm      = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
         end
         default: kept = 1'b0;
      endcase

      // x0 is never written
      ctrl_d.writes_rd = kept && !ctrl_d.is_store && (ctrl_d.rd != '0);
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_start <= 1'b0;
      end else begin
         o_start <= i_instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_instr_valid) begin
         o_ctrl <= ctrl_d;
      end
   end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import rv_serial_pkg::*; #(
   parameter word_t RESET_PC = 32'h0
) (
   input  logic   clk,
   input  logic   i_rst_n,
   input  logic   i_retire,
   output logic   o_ibus_cyc,
   output word_t  o_ibus_adr,
   input  word_t  i_ibus_rdt,
   input  logic   i_ibus_ack,
   output instr_t o_instr,
   output logic   o_instr_valid
);

   word_t pc;
   logic  started;

   assign o_ibus_adr = pc;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc            <= RESET_PC;
         started       <= 1'b0;
         o_ibus_cyc    <= 1'b0;
         o_instr_valid <= 1'b0;
      end else begin
         o_instr_valid <= 1'b0;
         // First fetch right after reset
         if (!started) begin
            started    <= 1'b1;
            o_ibus_cyc <= 1'b1;
         end
         if (o_ibus_cyc && i_ibus_ack) begin
            o_ibus_cyc    <= 1'b0;
            o_instr_valid <= 1'b1;
         end
         if (i_retire) begin
            pc         <= pc + 32'd4;
            o_ibus_cyc <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (o_ibus_cyc && i_ibus_ack) begin
         o_instr <= i_ibus_rdt;
      end
   end

endmodule

// ==== logic/rv_serial_pkg.sv ====
package rv_serial_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = 5;

   typedef logic [XLEN-1:0]   word_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Major opcodes that are executed, all others retire as no-ops
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   // Same 32-bit word, read in the layout the opcode selects
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      u_fmt_t u;
   } instr_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef struct packed {
      alu_op_e   alu_op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      use_imm;
      logic      zero_a;
      logic      writes_rd;
      logic      is_store;
      word_t     imm;
   } exec_ctrl_t;

   typedef struct packed {
      logic      en;
      reg_addr_t rd;
      word_t     data;
   } wb_t;

   typedef struct packed {
      word_t adr;
      word_t dat;
   } store_req_t;

endpackage
